// File: logic/exu_params.svh
`ifndef EXU_PARAMS_SVH
`define EXU_PARAMS_SVH

`define EXU_WORD_W       64
`define EXU_APB_ADDR_W   12
`define EXU_APB_DATA_W   32
`define EXU_MEM_WORDS    256
`define EXU_FIFO_DEPTH   4

`define REG_SRC1_LO      12'h000
`define REG_SRC1_HI      12'h004
`define REG_SRC2_LO      12'h008
`define REG_SRC2_HI      12'h00C
`define REG_OP           12'h010
`define REG_STATUS       12'h014   // [2:0] queue count, [8] head zero flag
`define REG_RES_LO       12'h018
`define REG_RES_HI       12'h01C   // read pops the queue head
`define REG_MADDR        12'h020
`define REG_MDATA_LO     12'h024
`define REG_MDATA_HI     12'h028   // write commits {hi, lo} to memory

`endif

// File: logic/exu_pkg.sv
`default_nettype none

`include "exu_params.svh"

package exu_pkg;

    typedef logic [`EXU_WORD_W-1:0]                 exu_word_t;
    typedef logic [`EXU_WORD_W-1:0]                 exu_addr_t;
    typedef logic [$clog2(`EXU_MEM_WORDS)-1:0]      exu_midx_t;   // address bits 10:3
    typedef logic [$clog2(`EXU_FIFO_DEPTH+1)-1:0]   exu_count_t;
    typedef logic [`EXU_APB_ADDR_W-1:0]             exu_apb_addr_t;
    typedef logic [`EXU_APB_DATA_W-1:0]             exu_apb_data_t;

    typedef enum logic [4:0] {
        OP_ADDW  = 5'h00,
        OP_ADD   = 5'h01,
        OP_ADDH  = 5'h02,
        OP_LWU   = 5'h03,
        OP_LD    = 5'h04,
        OP_LBU   = 5'h05,
        OP_SUB   = 5'h06,
        OP_SUBN  = 5'h07,
        OP_SLTU  = 5'h08,
        OP_SRA   = 5'h09,
        OP_AND   = 5'h0A,
        OP_ANDM  = 5'h0B,   // both operands from memory
        OP_SLLW  = 5'h0C,
        OP_SLLWM = 5'h0D,
        OP_REMU  = 5'h0E,
        OP_XOR   = 5'h0F,
        OP_XORM  = 5'h10
    } exu_op_e;

endpackage

`default_nettype wire

// File: logic/exu_apb_regs.sv
`default_nettype none

`include "exu_params.svh"

module exu_apb_regs import exu_pkg::*; (
    input  logic          pclk,
    input  logic          reset,
    input  logic          psel,
    input  logic          penable,
    input  logic          pwrite,
    input  exu_apb_addr_t paddr,
    input  exu_apb_data_t pwdata,
    output exu_apb_data_t prdata,
    output logic          pready,
    output logic          pslverr,
    input  exu_word_t     head_data,
    input  logic          head_zero,
    input  exu_count_t    count,
    output logic          issue_valid,
    output exu_op_e       issue_op,
    output exu_word_t     issue_src1,
    output exu_word_t     issue_src2,
    output logic          mem_we,
    output exu_midx_t     mem_widx,
    output exu_word_t     mem_wdata,
    output logic          pop
);

    exu_word_t     src1;
    exu_word_t     src2;
    exu_op_e       last_op;
    exu_midx_t     maddr;
    exu_apb_data_t mdata_lo;
    exu_apb_data_t mdata_hi;
    exu_count_t    credits;
    logic          mapped;
    logic          read_only;
    logic          op_bad;
    logic          empty_read;
    logic          err;
    logic          done;
    logic          wr_ok;
    logic          rd_ok;

    function automatic logic op_known(exu_apb_data_t code);
        logic known;
        known = 1'b0;
        case (code[4:0])
            OP_ADDW, OP_ADD, OP_ADDH, OP_LWU, OP_LD, OP_LBU,
            OP_SUB, OP_SUBN, OP_SLTU, OP_SRA, OP_AND, OP_ANDM,
            OP_SLLW, OP_SLLWM, OP_REMU, OP_XOR, OP_XORM: known = 1'b1;
            default: known = 1'b0;
        endcase
        return known && (code[31:5] == '0);
    endfunction

    always_comb begin
        mapped    = 1'b1;
        read_only = 1'b0;
        prdata    = '0;
        case (paddr)
            `REG_SRC1_LO:  prdata = src1[31:0];
            `REG_SRC1_HI:  prdata = src1[63:32];
            `REG_SRC2_LO:  prdata = src2[31:0];
            `REG_SRC2_HI:  prdata = src2[63:32];
            `REG_OP:       prdata = exu_apb_data_t'(last_op);
            `REG_STATUS: begin
                prdata    = {23'b0, head_zero, 5'b0, count};
                read_only = 1'b1;
            end
            `REG_RES_LO: begin
                prdata    = head_data[31:0];
                read_only = 1'b1;
            end
            `REG_RES_HI: begin
                prdata    = head_data[63:32];
                read_only = 1'b1;
            end
            `REG_MADDR:    prdata = exu_apb_data_t'(maddr);
            `REG_MDATA_LO: prdata = mdata_lo;
            `REG_MDATA_HI: prdata = mdata_hi;
            default:       mapped = 1'b0;
        endcase
    end

    assign op_bad     = (paddr == `REG_OP) && !op_known(pwdata);
    assign empty_read = !pwrite && (count == '0) &&
                        ((paddr == `REG_RES_LO) || (paddr == `REG_RES_HI));
    assign err        = !mapped || (pwrite && (read_only || op_bad)) || empty_read;

    // no credit left, so a valid op write waits for a pop
    assign pready  = !(psel && penable && pwrite && (paddr == `REG_OP) && !op_bad &&
                       (credits == '0));
    assign done    = psel && penable && pready;
    assign pslverr = done && err;
    assign wr_ok   = done && pwrite && !err;
    assign rd_ok   = done && !pwrite && !err;

    assign issue_valid = wr_ok && (paddr == `REG_OP);
    assign issue_op    = exu_op_e'(pwdata[4:0]);
    assign issue_src1  = src1;
    assign issue_src2  = src2;

    assign mem_we    = wr_ok && (paddr == `REG_MDATA_HI);
    assign mem_widx  = maddr;
    assign mem_wdata = {pwdata, mdata_lo};

    assign pop = rd_ok && (paddr == `REG_RES_HI);

    always_ff @(posedge pclk) begin
        if (reset) begin
            credits <= exu_count_t'(`EXU_FIFO_DEPTH);
        end else begin
            case ({issue_valid, pop})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;   // none or both
            endcase
        end
    end

    always_ff @(posedge pclk) begin
        if (wr_ok) begin
            case (paddr)
                `REG_SRC1_LO:  src1[31:0]  <= pwdata;
                `REG_SRC1_HI:  src1[63:32] <= pwdata;
                `REG_SRC2_LO:  src2[31:0]  <= pwdata;
                `REG_SRC2_HI:  src2[63:32] <= pwdata;
                `REG_OP:       last_op     <= issue_op;
                `REG_MADDR:    maddr       <= pwdata[$bits(exu_midx_t)-1:0];
                `REG_MDATA_LO: mdata_lo    <= pwdata;
                `REG_MDATA_HI: mdata_hi    <= pwdata;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/exu_agen.sv
`default_nettype none

module exu_agen import exu_pkg::*; (
    input  logic      pclk,
    input  logic      reset,
    input  logic      issue_valid,
    input  exu_op_e   issue_op,
    input  exu_word_t issue_src1,
    input  exu_word_t issue_src2,
    output logic      s1_valid,
    output exu_op_e   s1_op,
    output exu_word_t s1_src1,
    output exu_word_t s1_src2,
    output exu_addr_t s1_addr_a,
    output exu_addr_t s1_addr_b
);

    exu_addr_t addr_a;
    exu_addr_t addr_b;

    always_comb begin
        addr_a = issue_src1 + issue_src2;   // single loads
        addr_b = '0;
        case (issue_op)
            OP_ANDM, OP_SLLWM: begin
                addr_a = issue_src1;
                addr_b = issue_src2;
            end
            OP_XORM: addr_a = issue_src1;   // src2 stays an operand
            default: ;
        endcase
    end

    always_ff @(posedge pclk) begin
        if (reset) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= issue_valid;
        end
    end

    always_ff @(posedge pclk) begin
        s1_op     <= issue_op;
        s1_src1   <= issue_src1;
        s1_src2   <= issue_src2;
        s1_addr_a <= addr_a;
        s1_addr_b <= addr_b;
    end

endmodule

`default_nettype wire

// File: logic/exu_dmem.sv
`default_nettype none

`include "exu_params.svh"

module exu_dmem import exu_pkg::*; (
    input  logic      pclk,
    input  logic      reset,
    input  logic      s1_valid,
    input  exu_op_e   s1_op,
    input  exu_word_t s1_src1,
    input  exu_word_t s1_src2,
    input  exu_addr_t s1_addr_a,
    input  exu_addr_t s1_addr_b,
    input  logic      mem_we,
    input  exu_midx_t mem_widx,
    input  exu_word_t mem_wdata,
    output logic      s2_valid,
    output exu_op_e   s2_op,
    output exu_word_t s2_src1,
    output exu_word_t s2_src2,
    output exu_addr_t s2_addr_a,
    output exu_word_t s2_rdata_a,
    output exu_word_t s2_rdata_b
);

    exu_word_t mem [`EXU_MEM_WORDS];
    exu_midx_t idx_a;
    exu_midx_t idx_b;

    // word index, byte lane bits dropped
    assign idx_a = s1_addr_a[3 +: $bits(exu_midx_t)];
    assign idx_b = s1_addr_b[3 +: $bits(exu_midx_t)];

    always_ff @(posedge pclk) begin
        if (mem_we) begin
            mem[mem_widx] <= mem_wdata;
        end
        s2_rdata_a <= mem[idx_a];   // old data on a same-cycle write
        s2_rdata_b <= mem[idx_b];
        s2_op      <= s1_op;
        s2_src1    <= s1_src1;
        s2_src2    <= s1_src2;
        s2_addr_a  <= s1_addr_a;
    end

    always_ff @(posedge pclk) begin
        if (reset) begin
            s2_valid <= 1'b0;
        end else begin
            s2_valid <= s1_valid;
        end
    end

endmodule

`default_nettype wire

// File: logic/exu_alu.sv
`default_nettype none

module exu_alu import exu_pkg::*; (
    input  logic      pclk,
    input  logic      reset,
    input  logic      s2_valid,
    input  exu_op_e   s2_op,
    input  exu_word_t s2_src1,
    input  exu_word_t s2_src2,
    input  exu_addr_t s2_addr_a,
    input  exu_word_t s2_rdata_a,
    input  exu_word_t s2_rdata_b,
    output logic      res_valid,
    output exu_word_t res_data,
    output logic      res_zero
);

    exu_word_t sum;
    exu_word_t diff;
    exu_word_t sll_src;
    exu_word_t sll_mem;
    exu_word_t result;
    logic      zero;

    assign sum     = s2_src1 + s2_src2;
    assign diff    = s2_src1 - s2_src2;
    assign sll_src = s2_src1 << s2_src2[5:0];
    assign sll_mem = s2_rdata_a << s2_rdata_b[5:0];

    always_comb begin
        result = '0;
        zero   = 1'b0;
        case (s2_op)
            OP_ADDW:  result = {32'b0, sum[31:0]};
            OP_ADD:   result = sum;
            OP_ADDH:  result = {48'b0, sum[15:0]};
            OP_LWU:   result = {32'b0, s2_rdata_a[s2_addr_a[2]*32 +: 32]};   // half by bit 2
            OP_LD:    result = s2_rdata_a;
            OP_LBU:   result = {56'b0, s2_rdata_a[s2_addr_a[2:0]*8 +: 8]};
            OP_SUB: begin
                result = diff;
                zero   = (diff == '0);
            end
            OP_SUBN: begin
                result = diff;
                zero   = (diff != '0);   // inverted sense
            end
            OP_SLTU:  result = (s2_src1 < s2_src2) ? 64'd1 : 64'd0;
            OP_SRA:   result = $signed(s2_src1) >>> s2_src2[5:0];
            OP_AND:   result = s2_src1 & s2_src2;
            OP_ANDM:  result = s2_rdata_a & s2_rdata_b;
            OP_SLLW:  result = {32'b0, sll_src[31:0]};
            OP_SLLWM: result = {32'b0, sll_mem[31:0]};
            OP_REMU: begin
                if (s2_src2 == '0) begin
                    result = s2_src1;   // divide by zero keeps the dividend
                end else begin
                    result = s2_src1 % s2_src2;
                end
            end
            OP_XOR:   result = s2_src1 ^ s2_src2;
            OP_XORM:  result = s2_rdata_a ^ s2_src2;
            default:  result = '0;
        endcase
    end

    always_ff @(posedge pclk) begin
        if (reset) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= s2_valid;
        end
    end

    always_ff @(posedge pclk) begin
        res_data <= result;
        res_zero <= zero;
    end

endmodule

`default_nettype wire

// File: logic/exu_result_fifo.sv
`default_nettype none

`include "exu_params.svh"

module exu_result_fifo import exu_pkg::*; (
    input  logic       pclk,
    input  logic       reset,
    input  logic       res_valid,
    input  exu_word_t  res_data,
    input  logic       res_zero,
    input  logic       pop,
    output exu_word_t  head_data,
    output logic       head_zero,
    output exu_count_t count
);

    localparam int PTR_W = $clog2(`EXU_FIFO_DEPTH);

    exu_word_t  data_q [`EXU_FIFO_DEPTH];
    logic       zero_q [`EXU_FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic       do_pop;

    assign do_pop    = pop && (count != '0);
    assign head_data = data_q[rd_ptr];
    assign head_zero = zero_q[rd_ptr];

    always_ff @(posedge pclk) begin
        if (res_valid) begin
            data_q[wr_ptr] <= res_data;   // room is guaranteed by issue credits
            zero_q[wr_ptr] <= res_zero;
        end
    end

    always_ff @(posedge pclk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            wr_ptr <= wr_ptr + PTR_W'(res_valid);
            rd_ptr <= rd_ptr + PTR_W'(do_pop);
            count  <= count + exu_count_t'(res_valid) - exu_count_t'(do_pop);
        end
    end

endmodule

`default_nettype wire

// File: logic/exu_top.sv
`default_nettype none

module exu_top import exu_pkg::*; (
    input  logic          pclk,
    input  logic          reset,
    input  logic          psel,
    input  logic          penable,
    input  logic          pwrite,
    input  exu_apb_addr_t paddr,
    input  exu_apb_data_t pwdata,
    output exu_apb_data_t prdata,
    output logic          pready,
    output logic          pslverr
);

    logic       issue_valid;
    exu_op_e    issue_op;
    exu_word_t  issue_src1;
    exu_word_t  issue_src2;
    logic       s1_valid;
    exu_op_e    s1_op;
    exu_word_t  s1_src1;
    exu_word_t  s1_src2;
    exu_addr_t  s1_addr_a;
    exu_addr_t  s1_addr_b;
    logic       s2_valid;
    exu_op_e    s2_op;
    exu_word_t  s2_src1;
    exu_word_t  s2_src2;
    exu_addr_t  s2_addr_a;
    exu_word_t  s2_rdata_a;
    exu_word_t  s2_rdata_b;
    logic       res_valid;
    exu_word_t  res_data;
    logic       res_zero;
    exu_word_t  head_data;
    logic       head_zero;
    exu_count_t count;
    logic       pop;
    logic       mem_we;
    exu_midx_t  mem_widx;
    exu_word_t  mem_wdata;

    exu_apb_regs u_regs (
        .pclk, .reset, .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr, .head_data, .head_zero, .count,
        .issue_valid, .issue_op, .issue_src1, .issue_src2,
        .mem_we, .mem_widx, .mem_wdata, .pop
    );

    exu_agen u_agen (
        .pclk, .reset, .issue_valid, .issue_op, .issue_src1, .issue_src2,
        .s1_valid, .s1_op, .s1_src1, .s1_src2, .s1_addr_a, .s1_addr_b
    );

    exu_dmem u_dmem (
        .pclk, .reset, .s1_valid, .s1_op, .s1_src1, .s1_src2, .s1_addr_a, .s1_addr_b,
        .mem_we, .mem_widx, .mem_wdata,
        .s2_valid, .s2_op, .s2_src1, .s2_src2, .s2_addr_a, .s2_rdata_a, .s2_rdata_b
    );

    exu_alu u_alu (
        .pclk, .reset, .s2_valid, .s2_op, .s2_src1, .s2_src2, .s2_addr_a,
        .s2_rdata_a, .s2_rdata_b, .res_valid, .res_data, .res_zero
    );

    exu_result_fifo u_fifo (
        .pclk, .reset, .res_valid, .res_data, .res_zero, .pop,
        .head_data, .head_zero, .count
    );

endmodule

`default_nettype wire

// File: tb/exu_properties.sv
`default_nettype none

`include "exu_params.svh"

module exu_properties import exu_pkg::*; (
    input logic          pclk,
    input logic          reset,
    input logic          psel,
    input logic          penable,
    input logic          pwrite,
    input exu_apb_addr_t paddr,
    input logic          pready,
    input logic          pslverr,
    input logic          res_valid
);

    logic op_access;
    logic op_done;

    assign op_access = psel && penable && pwrite && (paddr == `REG_OP);
    assign op_done   = op_access && pready && !pslverr;   // accepted operation

    // wait states only come from a REG_OP write
    a_ready_rule: assert property (@(posedge pclk) disable iff (reset)
        (!op_access) |-> pready)
        else $error("pready low outside a REG_OP write");

    a_err_in_xfer: assert property (@(posedge pclk) disable iff (reset)
        pslverr |-> (psel && penable && pready))
        else $error("pslverr outside a completing transfer");

    a_op_push: assert property (@(posedge pclk) disable iff (reset)
        op_done |-> ##3 res_valid)
        else $error("accepted operation did not reach the result queue");

    a_push_has_op: assert property (@(posedge pclk) disable iff (reset)
        res_valid |-> $past(op_done, 3))
        else $error("result pushed without an accepted operation");

endmodule

`default_nettype wire

// File: tb/exu_tb.sv
`default_nettype none

`include "exu_params.svh"

module exu_tb import exu_pkg::*; ();

    localparam int MAX_WAIT = 50;

    typedef struct {
        exu_op_e   op;
        exu_word_t src1;
        exu_word_t src2;
        exu_word_t exp;
        logic      zero;
    } row_t;

    logic          pclk;
    logic          reset;
    logic          psel;
    logic          penable;
    logic          pwrite;
    exu_apb_addr_t paddr;
    exu_apb_data_t pwdata;
    exu_apb_data_t prdata;
    logic          pready;
    logic          pslverr;

    logic [15:0]   lfsr;
    exu_word_t     mem_model [`EXU_MEM_WORDS];   // mirror of the DUT memory
    row_t          table_q [$];
    row_t          burst [5];

    exu_top u_exu_top (
        .pclk, .reset, .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr
    );

    bind exu_top exu_properties u_props (
        .pclk, .reset, .psel, .penable, .pwrite, .paddr, .pready, .pslverr, .res_valid
    );

    initial pclk = 1'b0;
    always #10 pclk = ~pclk;

    function automatic exu_word_t rand_bits(int n);
        exu_word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[62:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);   // galois, taps 16,14,13,11
        end
        return v;
    endfunction

    function automatic exu_word_t model_result(exu_op_e op, exu_word_t a, exu_word_t b);
        exu_word_t ea;
        exu_word_t wa;
        exu_word_t t;
        ea = a + b;
        wa = mem_model[ea[10:3]];
        case (op)
            OP_ADDW:  return {32'b0, ea[31:0]};
            OP_ADD:   return ea;
            OP_ADDH:  return {48'b0, ea[15:0]};
            OP_LWU:   return ea[2] ? {32'b0, wa[63:32]} : {32'b0, wa[31:0]};
            OP_LD:    return wa;
            OP_LBU:   return (wa >> {ea[2:0], 3'b000}) & 64'hFF;
            OP_SUB:   return a - b;
            OP_SUBN:  return a - b;
            OP_SLTU:  return (a < b) ? 64'd1 : 64'd0;
            OP_SRA:   return exu_word_t'($signed(a) >>> b[5:0]);
            OP_AND:   return a & b;
            OP_ANDM:  return mem_model[a[10:3]] & mem_model[b[10:3]];
            OP_SLLW: begin
                t = a << b[5:0];
                return {32'b0, t[31:0]};
            end
            OP_SLLWM: begin
                t = mem_model[a[10:3]] << mem_model[b[10:3]][5:0];
                return {32'b0, t[31:0]};
            end
            OP_REMU:  return (b == '0) ? a : a % b;
            OP_XOR:   return a ^ b;
            OP_XORM:  return mem_model[a[10:3]] ^ b;
            default:  return '0;
        endcase
    endfunction

    function automatic row_t make_row(exu_op_e op, exu_word_t a, exu_word_t b);
        row_t r;
        r.op   = op;
        r.src1 = a;
        r.src2 = b;
        r.exp  = model_result(op, a, b);
        r.zero = (op == OP_SUB) ? (a == b) : (op == OP_SUBN) ? (a != b) : 1'b0;
        return r;
    endfunction

    task automatic add_row(exu_op_e op, exu_word_t a, exu_word_t b);
        table_q.push_back(make_row(op, a, b));
    endtask

    task automatic report_failure(string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_word(exu_word_t got, exu_word_t exp, string what);
        if (got !== exp) begin
            $display("Fail at time %0t: %s, got %h, expected %h", $time, what, got, exp);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_flag(logic got, logic exp, string what);
        if (got !== exp) begin
            $display("Fail at time %0t: %s, got %b, expected %b", $time, what, got, exp);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_count(exu_count_t got, exu_count_t exp, string what);
        if (got !== exp) begin
            $display("Fail at time %0t: %s, got %0d, expected %0d", $time, what, got, exp);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    // called 2 units after a rising edge, returns at the same point
    task automatic apb_xfer(input logic wr, input exu_apb_addr_t addr, input exu_apb_data_t wdata,
                            output exu_apb_data_t rdata, output logic err);
        int waits;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge pclk);
        #2;
        penable = 1'b1;
        waits   = 0;
        @(negedge pclk);
        while (!pready) begin
            waits++;
            if (waits > MAX_WAIT) begin
                report_failure($sformatf("timeout waiting for pready at address %h", addr));
            end
            @(negedge pclk);
        end
        rdata = prdata;   // stable until the completing edge
        err   = pslverr;
        @(posedge pclk);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(exu_apb_addr_t addr, exu_apb_data_t data);
        exu_apb_data_t rd;
        logic          err;
        apb_xfer(1'b1, addr, data, rd, err);
        if (err) begin
            report_failure($sformatf("unexpected pslverr on write to address %h", addr));
        end
    endtask

    task automatic apb_read(input exu_apb_addr_t addr, output exu_apb_data_t data);
        logic err;
        apb_xfer(1'b0, addr, '0, data, err);
        if (err) begin
            report_failure($sformatf("unexpected pslverr on read of address %h", addr));
        end
    endtask

    task automatic fill_memory();
        exu_word_t w;
        for (int i = 0; i < `EXU_MEM_WORDS; i++) begin
            w            = rand_bits(64);
            mem_model[i] = w;
            apb_write(`REG_MADDR, exu_apb_data_t'(i));
            apb_write(`REG_MDATA_LO, w[31:0]);
            apb_write(`REG_MDATA_HI, w[63:32]);
        end
    endtask

    task automatic write_operands(row_t r);
        apb_write(`REG_SRC1_LO, r.src1[31:0]);
        apb_write(`REG_SRC1_HI, r.src1[63:32]);
        apb_write(`REG_SRC2_LO, r.src2[31:0]);
        apb_write(`REG_SRC2_HI, r.src2[63:32]);
    endtask

    task automatic issue_row(row_t r);
        write_operands(r);
        apb_write(`REG_OP, exu_apb_data_t'(r.op));
    endtask

    task automatic wait_count(exu_count_t n);
        exu_apb_data_t st;
        int            tries;
        tries = 0;
        apb_read(`REG_STATUS, st);
        while (exu_count_t'(st[2:0]) != n) begin
            tries++;
            if (tries > MAX_WAIT) begin
                report_failure($sformatf("queue count never reached %0d", n));
            end
            apb_read(`REG_STATUS, st);
        end
    endtask

    task automatic check_head(row_t r, string what, exu_count_t exp_cnt);
        exu_apb_data_t st;
        exu_apb_data_t lo;
        exu_apb_data_t hi;
        apb_read(`REG_STATUS, st);
        apb_read(`REG_RES_LO, lo);
        apb_read(`REG_RES_HI, hi);   // pops the head
        check_count(exu_count_t'(st[2:0]), exp_cnt, {what, " queue count"});
        check_flag(st[8], r.zero, {what, " zero flag"});
        check_word({hi, lo}, r.exp, what);
    endtask

    // holds a REG_OP write while no credit is left, then withdraws it
    task automatic op_stalls(exu_op_e op);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = `REG_OP;
        pwdata  = exu_apb_data_t'(op);
        @(posedge pclk);
        #2;
        penable = 1'b1;
        repeat (8) begin
            @(negedge pclk);
            if (pready) begin
                report_failure("REG_OP write completed with no issue credit left");
            end
        end
        @(posedge pclk);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    initial begin
        exu_apb_data_t rd;
        logic          err;
        exu_op_e       rand_ops [6];
        exu_op_e       burst_ops [5];
        lfsr    = 16'd33818;
        reset   = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        repeat (5) @(posedge pclk);
        #2;
        reset = 1'b0;

        fill_memory();
        add_row(OP_ADDW, 64'h0000_0001_FFFF_FFFF, 64'h2);
        add_row(OP_ADD,  64'h8000_0000_0000_0001, 64'h7FFF_FFFF_FFFF_FFFF);
        add_row(OP_ADDH, 64'h1234_5678_9ABC_FFF0, 64'h20);
        add_row(OP_SUB,  64'h55, 64'h55);
        add_row(OP_SUB,  64'h10, 64'h55);
        add_row(OP_SUBN, 64'h55, 64'h55);
        add_row(OP_SUBN, 64'h100, 64'h1);
        add_row(OP_SLTU, 64'h5, 64'hFFFF_FFFF_FFFF_FFFF);
        add_row(OP_SLTU, 64'hFFFF_FFFF_FFFF_FFFF, 64'h5);
        add_row(OP_SRA,  64'hF000_0000_0000_0000, 64'h4);
        add_row(OP_SRA,  64'h7000_0000_0000_0000, 64'h41);   // only bits 5:0 count
        add_row(OP_AND,  64'hFF00_FF00_1234_5678, 64'h0FF0_0FF0_FFFF_0000);
        add_row(OP_SLLW, 64'h8000_0001, 64'h1);
        add_row(OP_SLLW, 64'h1234_5678, 64'h24);
        add_row(OP_REMU, 64'd1000, 64'd7);
        add_row(OP_REMU, 64'd1000, 64'd0);
        add_row(OP_XOR,  64'hDEAD_BEEF_0000_FFFF, 64'h0123_4567_89AB_CDEF);
        add_row(OP_LWU,  64'h100, 64'h4);
        add_row(OP_LWU,  64'h200, 64'h0);
        add_row(OP_LD,   64'h7F0, 64'h8);
        add_row(OP_LD,   64'h1_0000_0018, 64'h0);
        add_row(OP_LBU,  64'h300, 64'h5);
        add_row(OP_LBU,  64'h10, 64'h3);
        add_row(OP_LBU,  64'h7F8, 64'h7);
        add_row(OP_ANDM, 64'h40, 64'h88);
        add_row(OP_SLLWM, 64'h50, 64'h60);
        add_row(OP_SLLWM, 64'h3A8, 64'h110);
        add_row(OP_XORM, 64'h70, 64'hA5A5_5A5A_0F0F_F0F0);
        rand_ops = '{OP_ADD, OP_SUB, OP_SLTU, OP_SRA, OP_REMU, OP_XOR};
        foreach (rand_ops[i]) begin
            add_row(rand_ops[i], rand_bits(64), rand_bits(20));
        end
        foreach (table_q[i]) begin
            issue_row(table_q[i]);
            wait_count(1);
            check_head(table_q[i], $sformatf("row %0d %s", i, table_q[i].op.name()), 1);
        end

        // four ops use up the credits, the fifth must wait for a pop
        burst_ops = '{OP_ADD, OP_SUBN, OP_LD, OP_XORM, OP_SLLW};
        foreach (burst[i]) begin
            burst[i] = make_row(burst_ops[i], rand_bits(11), rand_bits(11));
        end
        for (int i = 0; i < 4; i++) begin
            issue_row(burst[i]);
        end
        wait_count(4);
        write_operands(burst[4]);
        op_stalls(burst[4].op);
        check_head(burst[0], "burst result 0", 4);
        apb_write(`REG_OP, exu_apb_data_t'(burst[4].op));
        wait_count(4);
        for (int i = 1; i < 5; i++) begin
            check_head(burst[i], $sformatf("burst result %0d", i), exu_count_t'(5 - i));
        end

        issue_row(table_q[0]);
        wait_count(1);
        apb_xfer(1'b1, `REG_OP, 32'h0000_0011, rd, err);
        check_flag(err, 1'b1, "pslverr on invalid operation code");
        apb_xfer(1'b0, 12'h030, '0, rd, err);
        check_flag(err, 1'b1, "pslverr on unmapped address");
        apb_xfer(1'b1, `REG_STATUS, '0, rd, err);
        check_flag(err, 1'b1, "pslverr on write to STATUS");
        check_head(table_q[0], "result after rejected accesses", 1);
        apb_xfer(1'b0, `REG_RES_HI, '0, rd, err);
        check_flag(err, 1'b1, "pslverr on RES_HI read of empty queue");
        apb_read(`REG_STATUS, rd);
        check_count(exu_count_t'(rd[2:0]), 0, "queue count after empty read");

        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+logic
logic/exu_pkg.sv
logic/exu_apb_regs.sv
logic/exu_agen.sv
logic/exu_dmem.sv
logic/exu_alu.sv
logic/exu_result_fifo.sv
logic/exu_top.sv
tb/exu_properties.sv
tb/exu_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module exu_tb -f flist.f \
    --Mdir obj_dir -o exu_sim

out=$(./obj_dir/exu_sim 2>&1) || true
echo "$out"
echo "$out" | grep -q "TEST OK"
